/* testbench/tracker_testdata.txt */
# All hex. F pc instr meta / I id pc instr meta rd uses_rd rs1_id rs2_id
# R id rd id_for_rd / E id pc / B cycles issue_valid fetch_ready
F 00001000 00500093 81
F 00001004 12345137 02
F 00001008 002081b3 83
I 0 00001000 00500093 81 01 1 0 0
I 1 00001004 12345137 02 02 1 0 0
B 4 0 1
R 0 01 0
B 4 0 1
R 1 02 1
I 2 00001008 002081b3 83 03 1 0 1
F 00002000 00100513 10
F 00002004 00200593 11
F 00002008 00300613 12
F 0000200c 00400693 13
F 00002010 00500713 14
F 00002014 00600793 95
F 00002018 00700813 96
B 3 1 0
E 3 00002000
E 4 00002004
E 5 00002008
E 6 0000200c
E 7 00002010
E 0 00002014
E 1 00002018
E 2 00001008
I 3 00002000 00100513 10 0a 1 0 0
I 4 00002004 00200593 11 0b 1 0 0
I 5 00002008 00300613 12 0c 1 0 0
I 6 0000200c 00400693 13 0d 1 0 0
I 7 00002010 00500713 14 0e 1 0 0
I 0 00002014 00600793 95 0f 1 0 0
I 1 00002018 00700813 96 10 1 0 0
R 2 03 2
F 00003000 00900513 20
I 2 00003000 00900513 20 0a 1 0 0
R 3 0a 2

/* src.f */
src/tracker_pkg.sv
src/id_management.sv
src/instruction_metadata.sv
src/register_status.sv
src/issue_control.sv
src/instruction_tracker_top.sv
testbench/tracker_properties.sv
testbench/tb_instruction_tracker.sv

/* Bender.yml */
package:
  name: instruction_tracker

sources:
  - src/tracker_pkg.sv
  - src/id_management.sv
  - src/instruction_metadata.sv
  - src/register_status.sv
  - src/issue_control.sv
  - src/instruction_tracker_top.sv
  - target: test
    files:
      - testbench/tracker_properties.sv
      - testbench/tb_instruction_tracker.sv

/* testbench/tb_instruction_tracker.sv */
// Instruction tracker testbench
// Replays command lines from the data file and checks issue packets,
// retire lookups, exception PCs and the stall and full conditions

`timescale 1ns/1ps

module tb_instruction_tracker;
    import tracker_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic          clk;
    logic          rst_n;
    logic          fetch_valid;
    fetch_packet_t fetch;
    logic          fetch_ready;
    logic          issue_valid;
    issue_packet_t issue;
    logic          issue_ready;
    logic          retire_valid;
    id_t           retire_id;
    retire_info_t  retire_info;
    id_t           exception_id;
    logic [31:0]   exception_pc;

    instruction_tracker_top #(
        .ID_WIDTH(ID_WIDTH),
        .MAX_IDS (MAX_IDS)
    ) dut (
        .clk, .rst_n, .fetch_valid, .fetch, .fetch_ready,
        .issue_valid, .issue, .issue_ready,
        .retire_valid, .retire_id, .retire_info,
        .exception_id, .exception_pc
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Reporting and compares
    //////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // Failure counters of both bound checker instances
    function automatic int unsigned property_failures();
        return dut.issue_ctrl.props.failures + dut.id_mgmt.props.failures;
    endfunction

    always @(negedge clk) begin
        if (property_failures() != 0)
            abort_run("A bound handshake or occupancy assertion failed");
    end

    task automatic check_issue(input issue_packet_t got, input issue_packet_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error at %0t ns: issue packet for ID %0d is %h, expected %h",
                                $time, exp.id, got, exp));
    endtask

    task automatic check_retire(input id_t id, input retire_info_t got,
                                input retire_info_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error at %0t ns: retire ID %0d gave rd %0d id %0d, %s %0d %0d",
                                $time, id, got.rd_addr, got.id_for_rd, "expected",
                                exp.rd_addr, exp.id_for_rd));
    endtask

    task automatic check_pc(input id_t id, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("** Error at %0t ns: exception PC for ID %0d is %h, expected %h",
                                $time, id, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("** Error at %0t ns: %s is %b, expected %b",
                                $time, name, got, exp));
    endtask

    //////////////////////////////
    // Waits
    //////////////////////////////

    task automatic wait_fetch_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!fetch_ready) begin
            if (cycles == TIMEOUT_CYCLES)
                abort_run("Timed out waiting for fetch_ready");
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_issue_valid();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!issue_valid) begin
            if (cycles == TIMEOUT_CYCLES)
                abort_run("Timed out waiting for issue_valid");
            cycles++;
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // Commands
    //////////////////////////////

    // Transfer lands on the edge after ready is seen
    task automatic push_fetch(input fetch_packet_t pkt);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch       <= pkt;
        wait_fetch_ready();
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    task automatic expect_issue(input issue_packet_t exp);
        @(posedge clk);
        issue_ready <= 1'b1;
        wait_issue_valid();
        check_issue(issue, exp);
        @(posedge clk);
        issue_ready <= 1'b0;
    endtask

    // Retire lookup is combinational, the retirement itself is the next edge
    task automatic retire_and_check(input id_t id, input retire_info_t exp);
        @(posedge clk);
        retire_valid <= 1'b1;
        retire_id    <= id;
        @(negedge clk);
        check_retire(id, retire_info, exp);
        @(posedge clk);
        retire_valid <= 1'b0;
    endtask

    task automatic expect_exception_pc(input id_t id, input logic [31:0] exp);
        @(posedge clk);
        exception_id <= id;
        @(negedge clk);
        check_pc(id, exception_pc, exp);
    endtask

    // Held issue_ready low, so a raised issue_valid stays raised
    task automatic hold_back_pressure(input int cycles, input logic exp_valid,
                                      input logic exp_ready);
        @(posedge clk);
        issue_ready <= 1'b0;
        repeat (cycles) @(posedge clk);
        @(negedge clk);
        check_flag("issue_valid", issue_valid, exp_valid);
        check_flag("fetch_ready", fetch_ready, exp_ready);
    endtask

    task automatic require_fields(input string cmd, input int got, input int want);
        if (got != want)
            abort_run($sformatf("Data file line %s has %0d fields instead of %0d",
                                cmd, got, want));
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int            fd;
        int            code;
        byte           cmd;
        string         rest;
        logic [31:0]   f [8];
        fetch_packet_t fetch_pkt;
        issue_packet_t exp_issue;
        retire_info_t  exp_retire;

        fetch_valid  <= 1'b0;
        fetch        <= '0;
        issue_ready  <= 1'b0;
        retire_valid <= 1'b0;
        retire_id    <= '0;
        exception_id <= '0;
        rst_n        <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("testbench/tracker_testdata.txt", "r");
        if (fd == 0)
            abort_run("Could not open testbench/tracker_testdata.txt");

        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1)
                break;
            case (cmd)
                // Column notes
                "#": code = $fgets(rest, fd);
                "F": begin
                    code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                    require_fields("F", code, 3);
                    fetch_pkt.pc    = f[0];
                    fetch_pkt.instr = f[1];
                    fetch_pkt.meta  = f[2][7:0];
                    push_fetch(fetch_pkt);
                end
                "I": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    require_fields("I", code, 8);
                    exp_issue.id      = id_t'(f[0]);
                    exp_issue.pc      = f[1];
                    exp_issue.instr   = f[2];
                    exp_issue.meta    = f[3][7:0];
                    exp_issue.rd_addr = f[4][4:0];
                    exp_issue.uses_rd = f[5][0];
                    exp_issue.rs1_id  = id_t'(f[6]);
                    exp_issue.rs2_id  = id_t'(f[7]);
                    expect_issue(exp_issue);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                    require_fields("R", code, 3);
                    exp_retire.rd_addr   = f[1][4:0];
                    exp_retire.id_for_rd = id_t'(f[2]);
                    retire_and_check(id_t'(f[0]), exp_retire);
                end
                "E": begin
                    code = $fscanf(fd, "%h %h", f[0], f[1]);
                    require_fields("E", code, 2);
                    expect_exception_pc(id_t'(f[0]), f[1]);
                end
                "B": begin
                    code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                    require_fields("B", code, 3);
                    hold_back_pressure(int'(f[0]), f[1][0], f[2][0]);
                end
                default: abort_run($sformatf("Unknown command '%c' in data file", cmd));
            endcase
        end
        $fclose(fd);

        // Let the last retirement settle before the verdict
        repeat (4) @(posedge clk);
        if (property_failures() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Bound assertions reported failures");
        end
    end

endmodule

/* testbench/tracker_properties.sv */
// Tracker handshake and occupancy checks
// Bound into the ID counters and the issue controller

`timescale 1ns/1ps

module tracker_properties #(
    parameter int MAX_IDS = tracker_pkg::MAX_IDS
) (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       fetch_valid,
    input logic                       fetch_ready,
    input logic                       retire_valid,
    input logic                       issue_valid,
    input logic                       issue_ready,
    input tracker_pkg::issue_packet_t issue
);

    // Read back by the testbench
    int unsigned failures = 0;

    // IDs in flight, counted from the fetch and retire strobes
    int occupancy;

    always @(posedge clk) begin
        if (!rst_n)
            occupancy <= 0;
        else
            occupancy <= occupancy + int'(fetch_valid && fetch_ready) - int'(retire_valid);
    end

    // No new ID while every ID is in flight
    full_blocks_fetch: assert property (
        @(posedge clk) disable iff (!rst_n) (occupancy == MAX_IDS) |-> !fetch_ready
    ) else begin
        $error("fetch_ready high with every ID in flight");
        failures++;
    end

    // Packet frozen until accepted
    issue_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue)
    ) else begin
        $error("issue packet changed or dropped under back-pressure");
        failures++;
    end

    // Nothing presented straight out of reset
    idle_after_reset: assert property (
        @(posedge clk) !rst_n |=> !issue_valid
    ) else begin
        $error("issue_valid high after reset");
        failures++;
    end

endmodule

// Occupancy side, issue inputs held idle
bind id_management tracker_properties #(.MAX_IDS(MAX_IDS)) props (
    .clk, .rst_n, .fetch_valid, .fetch_ready, .retire_valid,
    .issue_valid(1'b0), .issue_ready(1'b1), .issue('0)
);

// Issue side, occupancy inputs held idle
bind issue_control tracker_properties props (
    .clk, .rst_n, .fetch_valid(1'b0), .fetch_ready(1'b1), .retire_valid(1'b0),
    .issue_valid, .issue_ready, .issue
);

/* src/instruction_tracker_top.sv */
// Instruction tracker top level
// Connects the ID counters, metadata tables, register scoreboard
// and issue controller

`timescale 1ns/1ps

module instruction_tracker_top #(
    parameter int ID_WIDTH = tracker_pkg::ID_WIDTH,
    parameter int MAX_IDS  = tracker_pkg::MAX_IDS
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // Fetch stream
    input  logic                       fetch_valid,
    input  tracker_pkg::fetch_packet_t fetch,
    output logic                       fetch_ready,

    // Issue stream
    output logic                       issue_valid,
    output tracker_pkg::issue_packet_t issue,
    input  logic                       issue_ready,

    // Retire
    input  logic                       retire_valid,
    input  tracker_pkg::id_t           retire_id,
    output tracker_pkg::retire_info_t  retire_info,

    // Exception
    input  tracker_pkg::id_t           exception_id,
    output logic [31:0]                exception_pc
);
    import tracker_pkg::*;

    logic [ID_WIDTH-1:0] alloc_id;
    logic [ID_WIDTH-1:0] decode_id;
    logic [ID_WIDTH-1:0] retire_ptr;
    logic [ID_WIDTH-1:0] rs1_id;
    logic [ID_WIDTH-1:0] rs2_id;
    logic                pending_decode;
    logic                decode_advance;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic                rs1_busy;
    logic                rs2_busy;
    fetch_packet_t       decode_entry;

    // Handshake strobes
    wire fetch_we = fetch_valid & fetch_ready;
    wire set_we   = decode_advance & issue.uses_rd;
    // Only the youngest writer releases its register
    wire clear_we = retire_valid & (retire_info.id_for_rd == retire_ptr);

    id_management #(.MAX_IDS(MAX_IDS)) id_mgmt (
        .clk, .rst_n, .fetch_valid, .decode_advance, .retire_valid,
        .fetch_ready, .alloc_id, .decode_id, .retire_ptr, .pending_decode
    );

    instruction_metadata #(.MAX_IDS(MAX_IDS)) metadata (
        .clk, .fetch_we, .alloc_id, .fetch, .decode_id, .decode_entry,
        .issue_we(decode_advance), .issue, .rs1_addr, .rs2_addr,
        .rs1_id, .rs2_id, .retire_id, .retire_info, .exception_id, .exception_pc
    );

    register_status reg_status (
        .clk, .rst_n, .set_we, .set_rd(issue.rd_addr), .clear_we,
        .clear_rd(retire_info.rd_addr), .rs1_addr, .rs2_addr, .rs1_busy, .rs2_busy
    );

    issue_control issue_ctrl (
        .clk, .rst_n, .pending_decode, .decode_id, .decode_entry,
        .rs1_busy, .rs2_busy, .rs1_id, .rs2_id, .rs1_addr, .rs2_addr,
        .issue_valid, .issue, .issue_ready, .decode_advance
    );

endmodule

/* src/issue_control.sv */
// In-order issue controller
// Decodes the entry at the decode pointer, waits on busy source
// registers and presents the issue packet until it is accepted

`timescale 1ns/1ps

module issue_control (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pending_decode,
    input  tracker_pkg::id_t           decode_id,
    input  tracker_pkg::fetch_packet_t decode_entry,
    input  logic                       rs1_busy,
    input  logic                       rs2_busy,
    input  tracker_pkg::id_t           rs1_id,
    input  tracker_pkg::id_t           rs2_id,
    output logic [4:0]                 rs1_addr,
    output logic [4:0]                 rs2_addr,
    output logic                       issue_valid,
    output tracker_pkg::issue_packet_t issue,
    input  logic                       issue_ready,
    output logic                       decode_advance
);
    import tracker_pkg::*;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [1:0] {IDLE, DECODE, STALL, ISSUE} state_t;

    state_t state;
    state_t next_state;
    logic   uses_rd;
    logic   operands_free;
    logic   load_packet;

    //////////////////////////////
    // Decode
    //////////////////////////////
    always_comb begin
        rs1_addr = 5'd0;
        rs2_addr = 5'd0;
        uses_rd  = 1'b0;
        unique case (decode_entry.instr.r.opcode)
            // Two sources, R view
            OPC_OP: begin
                rs1_addr = decode_entry.instr.r.rs1;
                rs2_addr = decode_entry.instr.r.rs2;
                uses_rd  = 1'b1;
            end
            OPC_BRANCH, OPC_STORE: begin
                rs1_addr = decode_entry.instr.r.rs1;
                rs2_addr = decode_entry.instr.r.rs2;
            end
            // One source, I view
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                rs1_addr = decode_entry.instr.i.rs1;
                uses_rd  = 1'b1;
            end
            // No sources
            OPC_LUI, OPC_AUIPC, OPC_JAL: uses_rd = 1'b1;
            default: uses_rd = 1'b0;
        endcase
    end

    // Unused sources point at x0, which is never busy
    assign operands_free = !rs1_busy && !rs2_busy;

    //////////////////////////////
    // State machine
    //////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            IDLE:   if (pending_decode) next_state = DECODE;
            DECODE: next_state = operands_free ? ISSUE : STALL;
            STALL:  if (operands_free) next_state = ISSUE;
            ISSUE:  if (issue_ready) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= next_state;
    end

    // Packet captured on the way into ISSUE and held there
    assign load_packet = ((state == DECODE) || (state == STALL)) && operands_free;

    always_ff @(posedge clk) begin
        if (load_packet) begin
            issue.id      <= decode_id;
            issue.pc      <= decode_entry.pc;
            issue.instr   <= decode_entry.instr;
            issue.meta    <= decode_entry.meta;
            issue.rd_addr <= decode_entry.instr.r.rd;
            issue.uses_rd <= uses_rd;
            issue.rs1_id  <= rs1_id;
            issue.rs2_id  <= rs2_id;
        end
    end

    assign issue_valid    = (state == ISSUE);
    assign decode_advance = issue_valid && issue_ready;

endmodule

/* src/register_status.sv */
// Register scoreboard
// One busy bit per architectural register, set when a writer issues
// and cleared when the youngest writer of that register retires

`timescale 1ns/1ps

module register_status (
    input  logic       clk,
    input  logic       rst_n,

    // Set from issue
    input  logic       set_we,
    input  logic [4:0] set_rd,

    // Clear from retire
    input  logic       clear_we,
    input  logic [4:0] clear_rd,

    // Operand lookup
    input  logic [4:0] rs1_addr,
    input  logic [4:0] rs2_addr,
    output logic       rs1_busy,
    output logic       rs2_busy
);

    logic [31:0] busy;

    //////////////////////////////
    // Busy bits
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (clear_we)
                busy[clear_rd] <= 1'b0;
            // Set after clear, a new writer wins over an old one retiring
            if (set_we && (set_rd != 5'd0))
                busy[set_rd] <= 1'b1;
        end
    end

    //////////////////////////////
    // Lookup
    //////////////////////////////

    // x0 never has its bit set, so it always reads free
    assign rs1_busy = busy[rs1_addr];
    assign rs2_busy = busy[rs2_addr];

endmodule

/* src/instruction_metadata.sv */
// Per-ID instruction metadata
// PC, instruction word and branch metadata stored by ID, plus the
// youngest issued ID writing each architectural register

`timescale 1ns/1ps

module instruction_metadata #(
    parameter int MAX_IDS = tracker_pkg::MAX_IDS
) (
    input  logic                       clk,

    // Fetch side
    input  logic                       fetch_we,
    input  tracker_pkg::id_t           alloc_id,
    input  tracker_pkg::fetch_packet_t fetch,

    // Decode side
    input  tracker_pkg::id_t           decode_id,
    output tracker_pkg::fetch_packet_t decode_entry,

    // Issue side
    input  logic                       issue_we,
    input  tracker_pkg::issue_packet_t issue,
    input  logic [4:0]                 rs1_addr,
    input  logic [4:0]                 rs2_addr,
    output tracker_pkg::id_t           rs1_id,
    output tracker_pkg::id_t           rs2_id,

    // Retire side
    input  tracker_pkg::id_t           retire_id,
    output tracker_pkg::retire_info_t  retire_info,

    // Exception side
    input  tracker_pkg::id_t           exception_id,
    output logic [31:0]                exception_pc
);
    import tracker_pkg::*;

    logic [31:0]  pc_table    [MAX_IDS];
    instr_u       instr_table [MAX_IDS];
    branch_meta_t meta_table  [MAX_IDS];

    // Register number to youngest issued writer
    id_t          rd_to_id_table [32];

    //////////////////////////////
    // Table writes
    //////////////////////////////

    // Entry captured on the fetch transfer
    always_ff @(posedge clk) begin
        if (fetch_we) begin
            pc_table[alloc_id]    <= fetch.pc;
            instr_table[alloc_id] <= fetch.instr;
            meta_table[alloc_id]  <= fetch.meta;
        end
    end

    // Power-up mapping for registers never written
    initial rd_to_id_table = '{default: '0};

    // Later issues overwrite, so the entry always names the youngest writer
    always @(posedge clk) begin
        if (issue_we && issue.uses_rd)
            rd_to_id_table[issue.rd_addr] <= issue.id;
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    // Decode
    always_comb begin
        decode_entry.pc    = pc_table[decode_id];
        decode_entry.instr = instr_table[decode_id];
        decode_entry.meta  = meta_table[decode_id];
    end

    // Producers of the source operands
    assign rs1_id = rd_to_id_table[rs1_addr];
    assign rs2_id = rd_to_id_table[rs2_addr];

    // Retire lookup, rd is bits 11:7 of the stored word
    always_comb begin
        retire_info.rd_addr   = instr_table[retire_id].r.rd;
        retire_info.id_for_rd = rd_to_id_table[retire_info.rd_addr];
    end

    // Exception
    assign exception_pc = pc_table[exception_id];

endmodule

/* src/id_management.sv */
// In-flight ID management
// Circular allocate, decode and retire pointers plus occupancy,
// which throttles fetch once every ID is in use

`timescale 1ns/1ps

module id_management #(
    parameter int MAX_IDS = tracker_pkg::MAX_IDS
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch_valid,
    input  logic             decode_advance,
    input  logic             retire_valid,
    output logic             fetch_ready,
    output tracker_pkg::id_t alloc_id,
    output tracker_pkg::id_t decode_id,
    output tracker_pkg::id_t retire_ptr,
    output logic             pending_decode
);
    import tracker_pkg::*;

    localparam int CNT_W = $clog2(MAX_IDS + 1);

    logic             fetch_fire;
    logic [CNT_W-1:0] in_flight;
    logic [CNT_W-1:0] pending;

    // Wrap at MAX_IDS, which need not be a power of two
    function automatic id_t next_id(input id_t cur);
        if (cur == id_t'(MAX_IDS - 1))
            return '0;
        return cur + id_t'(1);
    endfunction

    assign fetch_fire = fetch_valid & fetch_ready;

    //////////////////////////////
    // Pointers
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alloc_id   <= '0;
            decode_id  <= '0;
            retire_ptr <= '0;
        end else begin
            if (fetch_fire)
                alloc_id <= next_id(alloc_id);
            if (decode_advance)
                decode_id <= next_id(decode_id);
            // Retirement is strictly in order
            if (retire_valid)
                retire_ptr <= next_id(retire_ptr);
        end
    end

    //////////////////////////////
    // Occupancy
    //////////////////////////////
    // Allocated but not yet retired
    always_ff @(posedge clk) begin
        if (!rst_n)
            in_flight <= '0;
        else if (fetch_fire && !retire_valid)
            in_flight <= in_flight + 1'b1;
        else if (!fetch_fire && retire_valid)
            in_flight <= in_flight - 1'b1;
    end

    // Allocated but not yet issued
    always_ff @(posedge clk) begin
        if (!rst_n)
            pending <= '0;
        else if (fetch_fire && !decode_advance)
            pending <= pending + 1'b1;
        else if (!fetch_fire && decode_advance)
            pending <= pending - 1'b1;
    end

    assign fetch_ready    = (in_flight != CNT_W'(MAX_IDS));
    assign pending_decode = (pending != '0);

endmodule

/* src/tracker_pkg.sv */
// Instruction tracker shared types
// ID width, instruction word views, branch metadata and the
// fetch, issue and retire packets passed between the tracker blocks

package tracker_pkg;

    // Default ID space
    parameter int ID_WIDTH = 3;
    parameter int MAX_IDS  = 8;

    typedef logic [ID_WIDTH-1:0] id_t;

    //////////////////////////////
    // Instruction word views
    //////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Same 32-bit word, decoded as R-type or I-type
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    // Predictor state carried alongside each instruction
    typedef struct packed {
        logic       taken;
        logic [6:0] history;
    } branch_meta_t;

    //////////////////////////////
    // Packets
    //////////////////////////////

    typedef struct packed {
        logic [31:0]  pc;
        instr_u       instr;
        branch_meta_t meta;
    } fetch_packet_t;

    typedef struct packed {
        id_t          id;
        logic [31:0]  pc;
        instr_u       instr;
        branch_meta_t meta;
        logic [4:0]   rd_addr;
        logic         uses_rd;
        id_t          rs1_id;
        id_t          rs2_id;
    } issue_packet_t;

    typedef struct packed {
        logic [4:0] rd_addr;
        id_t        id_for_rd;
    } retire_info_t;

endpackage
